// File: files.f
+incdir+include
src/z80_cb_pkg.sv
src/z80_cb_decode.sv
src/z80_shift_rotate.sv
src/z80_bit_ops.sv
src/z80_cb_issue.sv
src/z80_cb_state.sv
src/z80_cb_exec.sv
testbench/tb_z80_cb_exec.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_z80_cb_exec -o sim_tb || { echo "Build failed"; exit 1; }

output=$(./obj_dir/sim_tb 2>&1)
echo "$output"
echo "$output" | grep -q "Simulation PASSED" && exit 0 || exit 1

// File: testbench/tb_z80_cb_exec.sv
// ==========================================================================
// Testbench for the CB execution subsystem: reference model, stimulus
// tasks, credit handling, retire monitor and timeout.
// ==========================================================================

`timescale 1ns/1ps

`include "z80_regs.svh"

module tb_z80_cb_exec;

    localparam int          IN_DEPTH       = 4;
    localparam int          OUT_CREDITS    = 2;
    localparam logic [15:0] RESET_IP       = 16'h0100;
    localparam int          MAX_INSNS      = 600;  // Bound on words sent by all tests.
    localparam int          TIMEOUT_CYCLES = MAX_INSNS * 3 + 200;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    logic [15:0] in_insn;
    logic        in_credit;
    logic        out_credit = 1'b0;
    logic        retire_valid;
    logic [15:0] retire_ip;
    logic [7:0]  retire_result;
    logic [7:0]  retire_f;
    logic        retire_illegal;

    logic [7:0]  model_regs [8];  // Indexed by register code.
    logic [7:0]  model_f;
    logic [15:0] model_ip;
    logic [32:0] expected_q [$];  // {illegal, ip, result, f}.

    logic [31:0] lfsr_state;
    logic        auto_credit;
    int          sent_count     = 0;
    int          retired_count  = 0;
    int          credit_pulses  = 0;
    int          auto_granted   = 0;
    int          manual_granted = 0;
    int          returned_count = 0;
    int          cycle_count    = 0;

    z80_cb_exec #(
        .IN_DEPTH   (IN_DEPTH),
        .OUT_CREDITS(OUT_CREDITS),
        .RESET_IP   (RESET_IP)
    ) z80_cb_exec_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_valid      (in_valid),
        .in_insn       (in_insn),
        .in_credit     (in_credit),
        .out_credit    (out_credit),
        .retire_valid  (retire_valid),
        .retire_ip     (retire_ip),
        .retire_result (retire_result),
        .retire_f      (retire_f),
        .retire_illegal(retire_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d instructions retired",
                     cycle_count, retired_count, sent_count);
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // ======================================================================
    // Retire monitor and downstream credit return
    // ======================================================================

    always @(posedge clk) begin
        logic [32:0] exp_rec;
        if (in_credit) begin
            credit_pulses <= credit_pulses + 1;
        end
        if (retire_valid) begin
            if (expected_q.size() == 0) begin
                $display("A retire record arrived with no instruction outstanding");
                $display("Simulation FAILED");
                $fatal(1);
            end else begin
                exp_rec = expected_q.pop_front();
                check_value("retire_illegal", 32'(retire_illegal), 32'(exp_rec[32]));
                check_value("retire_ip", 32'(retire_ip), 32'(exp_rec[31:16]));
                check_value("retire_result", 32'(retire_result), 32'(exp_rec[15:8]));
                check_value("retire_f", 32'(retire_f), 32'(exp_rec[7:0]));
                retired_count <= retired_count + 1;
                if (auto_credit) begin
                    auto_granted <= auto_granted + 1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (returned_count < auto_granted + manual_granted) begin
            out_credit     <= 1'b1;  // One credit per cycle.
            returned_count <= returned_count + 1;
        end else begin
            out_credit <= 1'b0;
        end
    end

    // ======================================================================
    // Reference model and stimulus helpers
    // ======================================================================

    // Galois LFSR, one step per bit taken.
    function automatic logic [7:0] rand_bits(input int nbits);
        logic [7:0] value;
        logic       out_bit;
        value = 8'h00;
        for (int i = 0; i < nbits; i++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (out_bit) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            value = {value[6:0], out_bit};
        end
        return value;
    endfunction

    // Code 6 is (HL) for registers and SLL for shifts, so it maps to 7.
    function automatic logic [2:0] rand_code();
        logic [2:0] code;
        code = 3'(rand_bits(3));
        return (code == 3'd6) ? 3'd7 : code;
    endfunction

    function automatic logic [15:0] shift_insn(input logic [2:0] op, input logic [2:0] r);
        return {2'b00, op, r, 8'hCB};
    endfunction

    function automatic logic [15:0] bit_insn(input logic [1:0] kind, input logic [2:0] idx,
                                             input logic [2:0] r);
        return {kind, idx, r, 8'hCB};
    endfunction

    function automatic void model_step(input logic [15:0] insn);
        logic [7:0] opc;
        logic [2:0] r;
        logic [2:0] idx;
        logic [7:0] opnd;
        logic [7:0] res;
        logic [7:0] nf;
        logic       carry;
        logic       tested;
        int         ones;
        opc = insn[15:8];
        r   = opc[2:0];
        idx = opc[5:3];
        if (insn[7:0] != 8'hCB || r == 3'd6 || opc[7:3] == 5'b00110) begin
            expected_q.push_back({1'b1, model_ip, 8'h00, model_f});  // No state change.
        end else begin
            opnd = model_regs[r];
            res  = opnd;
            nf   = model_f;
            case (opc[7:6])
                2'd0: begin
                    case (idx)
                        3'd0:    res = {opnd[6:0], opnd[7]};           // RLC.
                        3'd1:    res = {opnd[0], opnd[7:1]};           // RRC.
                        3'd2:    res = {opnd[6:0], model_f[`FLAG_C_NUM]};
                        3'd3:    res = {model_f[`FLAG_C_NUM], opnd[7:1]};
                        3'd4:    res = {opnd[6:0], 1'b0};              // SLA.
                        3'd5:    res = {opnd[7], opnd[7:1]};           // SRA.
                        default: res = {1'b0, opnd[7:1]};              // SRL.
                    endcase
                    carry = (idx inside {3'd1, 3'd3, 3'd5, 3'd7}) ? opnd[0] : opnd[7];
                    ones  = 0;
                    for (int i = 0; i < 8; i++) begin
                        ones = ones + int'(res[i]);
                    end
                    nf[`FLAG_S_NUM] = res[7];
                    nf[`FLAG_Z_NUM] = (res == 8'h00);
                    nf[`FLAG_H_NUM] = 1'b0;
                    nf[`FLAG_V_NUM] = ((ones % 2) == 0);
                    nf[`FLAG_N_NUM] = 1'b0;
                    nf[`FLAG_C_NUM] = carry;
                end
                2'd1: begin
                    tested          = opnd[idx];
                    nf[`FLAG_S_NUM] = (idx == 3'd7) && tested;
                    nf[`FLAG_Z_NUM] = !tested;
                    nf[`FLAG_H_NUM] = 1'b1;
                    nf[`FLAG_V_NUM] = !tested;
                    nf[`FLAG_N_NUM] = 1'b0;
                end
                2'd2:    res = opnd & ~(8'h01 << idx);
                default: res = opnd | (8'h01 << idx);
            endcase
            if (opc[7:6] != 2'd1) begin
                model_regs[r] = res;
            end
            model_f = nf;
            expected_q.push_back({1'b0, model_ip, res, nf});
            model_ip = model_ip + 16'd2;
        end
    endfunction

    task automatic send_insn(input logic [15:0] insn);
        @(posedge clk);
        while (sent_count - credit_pulses >= IN_DEPTH) begin
            in_valid <= 1'b0;  // Out of input credits.
            @(posedge clk);
        end
        in_valid   <= 1'b1;
        in_insn    <= insn;
        sent_count = sent_count + 1;
        model_step(insn);
    endtask

    task automatic return_credit(input int count);
        @(posedge clk);
        manual_granted <= manual_granted + count;
    endtask

    // Builds a register value from SET and RES.
    task automatic load_reg(input logic [2:0] r, input logic [7:0] value);
        for (int i = 0; i < 8; i++) begin
            send_insn(bit_insn(value[i] ? 2'd3 : 2'd2, 3'(i), r));
        end
    endtask

    task automatic drain();
        @(posedge clk);
        in_valid <= 1'b0;
        while (retired_count < sent_count ||
               returned_count < auto_granted + manual_granted) begin
            @(posedge clk);
        end
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================

    task automatic shift_group_test();
        for (int op = 0; op < 8; op++) begin
            if (op != 6) begin
                for (int r = 0; r < 8; r++) begin
                    if (r != 6) begin
                        load_reg(3'(r), rand_bits(8));
                    end
                end
                for (int r = 0; r < 8; r++) begin
                    if (r != 6) begin
                        send_insn(shift_insn(3'(op), 3'(r)));
                    end
                end
            end
        end
        drain();
    endtask

    task automatic bit_group_test();
        load_reg(`REG_A, 8'h80);
        send_insn(bit_insn(2'd1, 3'd7, `REG_A));  // Set bit 7.
        send_insn(bit_insn(2'd1, 3'd6, `REG_A));
        load_reg(`REG_C, 8'h7F);
        send_insn(bit_insn(2'd1, 3'd7, `REG_C));  // Clear bit 7.
        send_insn(bit_insn(2'd1, 3'd0, `REG_C));
        load_reg(`REG_E, rand_bits(8));
        for (int i = 0; i < 8; i++) begin
            send_insn(bit_insn(2'd1, 3'(i), `REG_E));
        end
        // Later writes expose the register that BIT only looked at.
        send_insn(bit_insn(2'd2, 3'd3, `REG_A));
        send_insn(bit_insn(2'd3, 3'd0, `REG_C));
        send_insn(bit_insn(2'd3, 3'd1, `REG_E));
        for (int i = 0; i < 16; i++) begin
            send_insn(bit_insn(1'(rand_bits(1)) ? 2'd3 : 2'd2, 3'(rand_bits(3)),
                               rand_code()));
        end
        drain();
    endtask

    task automatic illegal_insn_test();
        logic [15:0] bad_list [7];
        bad_list = '{16'h30CB, 16'h37CB, 16'h06CB, 16'h5ECB, 16'hFECB, 16'h00ED, 16'hC7DD};
        for (int i = 0; i < 7; i++) begin
            send_insn(bad_list[i]);
            send_insn(shift_insn(3'd1, rand_code()));
        end
        drain();
    endtask

    task automatic ip_chain_test();
        load_reg(`REG_D, rand_bits(8));
        for (int i = 0; i < 16; i++) begin
            send_insn(shift_insn(rand_code(), `REG_D));
        end
        drain();
    endtask

    task automatic credit_test();
        int base;
        base = retired_count;
        @(posedge clk);
        auto_credit <= 1'b0;
        for (int i = 0; i < IN_DEPTH + OUT_CREDITS; i++) begin
            send_insn(shift_insn(rand_code(), rand_code()));
        end
        @(posedge clk);
        in_valid <= 1'b0;
        repeat (12) @(posedge clk);
        check_value("records while blocked", 32'(retired_count - base), 32'(OUT_CREDITS));
        return_credit(OUT_CREDITS);  // Frees the records held downstream.
        auto_credit <= 1'b1;
        drain();
        check_value("in_credit pulses", 32'(credit_pulses), 32'(retired_count));
    endtask

    initial begin
        lfsr_state  = 32'h76bf;
        arst_n      = 1'b0;
        in_valid    = 1'b0;
        in_insn     = 16'h0000;
        auto_credit = 1'b1;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = 8'h00;
        end
        model_f  = 8'h00;
        model_ip = RESET_IP;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        shift_group_test();
        bit_group_test();
        illegal_insn_test();
        ip_chain_test();
        credit_test();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: src/z80_cb_exec.sv
// ========================================================================
// CB instruction execution subsystem: issue queue, decoder, shift and
// bit units, and register state.
// ========================================================================

`timescale 1ns/1ps
`default_nettype none

module z80_cb_exec #(
    parameter int          IN_DEPTH    = 4,
    parameter int          OUT_CREDITS = 2,
    parameter logic [15:0] RESET_IP    = 16'h0100
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    input  logic [15:0] in_insn,
    output logic        in_credit,
    input  logic        out_credit,
    output logic        retire_valid,
    output logic [15:0] retire_ip,
    output logic [7:0]  retire_result,
    output logic [7:0]  retire_f,
    output logic        retire_illegal
);

    import z80_cb_pkg::*;

    logic       fire;
    cb_insn_u   head_insn;
    bit_kind_e  kind;
    shift_op_e  op;
    logic [2:0] bit_idx;
    logic [2:0] r;
    logic       legal;
    logic [7:0] operand;
    logic [7:0] f_cur;
    logic [7:0] shift_result, shift_f;
    logic [7:0] bit_result, bit_f;

    z80_cb_issue #(
        .IN_DEPTH   (IN_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) z80_cb_issue_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_insn   (in_insn),
        .out_credit(out_credit),
        .in_credit (in_credit),
        .fire      (fire),
        .head_insn (head_insn)
    );

    z80_cb_decode z80_cb_decode_inst (
        .head_insn(head_insn),
        .kind     (kind),
        .op       (op),
        .bit_idx  (bit_idx),
        .r        (r),
        .legal    (legal)
    );

    z80_shift_rotate z80_shift_rotate_inst (
        .op     (op),
        .operand(operand),
        .f_in   (f_cur),
        .result (shift_result),
        .f_out  (shift_f)
    );

    z80_bit_ops z80_bit_ops_inst (
        .kind   (kind),
        .bit_idx(bit_idx),
        .operand(operand),
        .f_in   (f_cur),
        .result (bit_result),
        .f_out  (bit_f)
    );

    z80_cb_state #(
        .RESET_IP(RESET_IP)
    ) z80_cb_state_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .fire          (fire),
        .legal         (legal),
        .kind          (kind),
        .r             (r),
        .shift_result  (shift_result),
        .shift_f       (shift_f),
        .bit_result    (bit_result),
        .bit_f         (bit_f),
        .operand       (operand),
        .f_cur         (f_cur),
        .retire_valid  (retire_valid),
        .retire_ip     (retire_ip),
        .retire_result (retire_result),
        .retire_f      (retire_f),
        .retire_illegal(retire_illegal)
    );

endmodule

`default_nettype wire

// File: src/z80_cb_state.sv
// ========================================================================
// Register file with operand read and write-back, and the retire record.
// ========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "z80_regs.svh"

module z80_cb_state #(
    parameter logic [15:0] RESET_IP = 16'h0100
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  fire,
    input  logic                  legal,
    input  z80_cb_pkg::bit_kind_e kind,
    input  logic [2:0]            r,
    input  logic [7:0]            shift_result,
    input  logic [7:0]            shift_f,
    input  logic [7:0]            bit_result,
    input  logic [7:0]            bit_f,
    output logic [7:0]            operand,
    output logic [7:0]            f_cur,
    output logic                  retire_valid,
    output logic [15:0]           retire_ip,
    output logic [7:0]            retire_result,
    output logic [7:0]            retire_f,
    output logic                  retire_illegal
);

    import z80_cb_pkg::*;

    logic [7:0]  reg_a, reg_b, reg_c, reg_d, reg_e, reg_h, reg_l, reg_f;
    logic [15:0] reg_ip;
    logic [7:0]  wdata;
    logic [7:0]  f_new;
    logic        do_write;

    always_comb begin
        case (r)
            `REG_A:  operand = reg_a;
            `REG_B:  operand = reg_b;
            `REG_C:  operand = reg_c;
            `REG_D:  operand = reg_d;
            `REG_E:  operand = reg_e;
            `REG_H:  operand = reg_h;
            `REG_L:  operand = reg_l;
            default: operand = 8'h00;  // (HL), illegal anyway.
        endcase
    end

    assign f_cur    = reg_f;
    assign wdata    = (kind == SHIFT_GRP) ? shift_result : bit_result;
    assign f_new    = (kind == SHIFT_GRP) ? shift_f : bit_f;
    assign do_write = fire && legal && (kind != BIT_TST);  // BIT only sets F.

    // ====================================================================
    // Architectural state
    // ====================================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            {reg_a, reg_b, reg_c, reg_d, reg_e, reg_h, reg_l, reg_f} <= '0;
            reg_ip <= RESET_IP;
        end else begin
            if (do_write) begin
                case (r)
                    `REG_A:  reg_a <= wdata;
                    `REG_B:  reg_b <= wdata;
                    `REG_C:  reg_c <= wdata;
                    `REG_D:  reg_d <= wdata;
                    `REG_E:  reg_e <= wdata;
                    `REG_H:  reg_h <= wdata;
                    `REG_L:  reg_l <= wdata;
                    default: reg_l <= reg_l;
                endcase
            end
            if (fire && legal) begin
                reg_f  <= f_new;
                reg_ip <= reg_ip + 16'd2;  // Two-byte opcode.
            end
        end
    end

    // ====================================================================
    // Retire record
    // ====================================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            retire_ip      <= reg_ip;  // IP of this instruction.
            retire_result  <= legal ? wdata : 8'h00;
            retire_f       <= legal ? f_new : reg_f;
            retire_illegal <= !legal;
        end
    end

endmodule

`default_nettype wire

// File: src/z80_cb_issue.sv
// ========================================================================
// Input queue with credit return, and the output credit counter that
// decides when the head instruction fires.
// ========================================================================

`timescale 1ns/1ps
`default_nettype none

module z80_cb_issue #(
    parameter int IN_DEPTH    = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    input  logic [15:0]          in_insn,
    input  logic                 out_credit,
    output logic                 in_credit,
    output logic                 fire,
    output z80_cb_pkg::cb_insn_u head_insn
);

    import z80_cb_pkg::*;

    localparam int PTR_W = $clog2(IN_DEPTH);
    localparam int CNT_W = $clog2(OUT_CREDITS + 1);

    cb_insn_u         queue_mem [IN_DEPTH];
    logic [PTR_W:0]   wr_ptr;     // Extra bit tells full from empty.
    logic [PTR_W:0]   rd_ptr;
    logic             empty;
    logic             full;
    logic [CNT_W-1:0] credit_cnt;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    assign fire      = !empty && (credit_cnt != '0);
    assign head_insn = queue_mem[rd_ptr[PTR_W-1:0]];

    // ====================================================================
    // Queue
    // ====================================================================

    always_ff @(posedge clk) begin
        if (in_valid) begin
            queue_mem[wr_ptr[PTR_W-1:0]] <= in_insn;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + (PTR_W + 1)'(1);
            end
            if (fire) begin
                rd_ptr <= rd_ptr + (PTR_W + 1)'(1);
            end
            in_credit <= fire;  // One credit back per pop.
        end
    end

    // ====================================================================
    // Output credits
    // ====================================================================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= CNT_W'(OUT_CREDITS);
        end else begin
            case ({fire, out_credit})
                2'b10:   credit_cnt <= credit_cnt - CNT_W'(1);
                2'b01:   credit_cnt <= credit_cnt + CNT_W'(1);
                default: credit_cnt <= credit_cnt; // Both or neither.
            endcase
        end
    end

    // Upstream must hold a credit, so a full queue never sees a push.
    assert property (@(posedge clk) disable iff (!arst_n) in_valid |-> !full)
        else $error("push into a full input queue");

    // Downstream returns no more credits than it was given.
    assert property (@(posedge clk) disable iff (!arst_n) credit_cnt <= OUT_CREDITS)
        else $error("output credit counter overflow");

endmodule

`default_nettype wire

// File: src/z80_bit_ops.sv
// ========================================================================
// BIT test flags and RES/SET results for CB 40-FF.
// ========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "z80_regs.svh"

module z80_bit_ops (
    input  z80_cb_pkg::bit_kind_e kind,
    input  logic [2:0]            bit_idx,
    input  logic [7:0]            operand,
    input  logic [7:0]            f_in,
    output logic [7:0]            result,
    output logic [7:0]            f_out
);

    import z80_cb_pkg::*;

    logic [7:0] mask;
    logic       bit_set;

    assign mask    = 8'h01 << bit_idx;
    assign bit_set = operand[bit_idx];

    always_comb begin
        result = operand;
        f_out  = f_in;
        case (kind)
            BIT_RES: result = operand & ~mask;
            BIT_SET: result = operand | mask;
            BIT_TST: begin
                // Z and V both mirror the inverted tested bit.
                f_out[`FLAG_S_NUM] = (bit_idx == 3'd7) && bit_set;
                f_out[`FLAG_Z_NUM] = ~bit_set;
                f_out[`FLAG_H_NUM] = 1'b1;
                f_out[`FLAG_V_NUM] = ~bit_set;
                f_out[`FLAG_N_NUM] = 1'b0;
            end
            default: begin
                result = operand; // Shift group, not used here.
                f_out  = f_in;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/z80_shift_rotate.sv
// ========================================================================
// Rotate and shift unit for CB 00-3F: result byte and new F.
// ========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "z80_regs.svh"

module z80_shift_rotate (
    input  z80_cb_pkg::shift_op_e op,
    input  logic [7:0]            operand,
    input  logic [7:0]            f_in,
    output logic [7:0]            result,
    output logic [7:0]            f_out
);

    import z80_cb_pkg::*;

    logic right;
    logic shove_bit;
    logic carry_out;

    // All right-going operations have odd codes.
    assign right = op[0];

    always_comb begin
        case (op)
            RLC:     shove_bit = operand[7];          // Wraps around.
            RRC:     shove_bit = operand[0];
            RL,
            RR:      shove_bit = f_in[`FLAG_C_NUM];   // Through carry.
            SRA:     shove_bit = operand[7];          // Keeps the sign.
            default: shove_bit = 1'b0;
        endcase
    end

    assign result    = right ? {shove_bit, operand[7:1]} : {operand[6:0], shove_bit};
    assign carry_out = right ? operand[0] : operand[7];

    // ====================================================================
    // Flags
    // ====================================================================

    always_comb begin
        f_out              = 8'h00;
        f_out[`FLAG_S_NUM] = result[7];
        f_out[`FLAG_Z_NUM] = (result == 8'h00);
        f_out[`FLAG_5_NUM] = f_in[`FLAG_5_NUM];  // Undocumented, kept.
        f_out[`FLAG_H_NUM] = 1'b0;
        f_out[`FLAG_3_NUM] = f_in[`FLAG_3_NUM];
        f_out[`FLAG_V_NUM] = parity8(result);    // Even parity.
        f_out[`FLAG_N_NUM] = 1'b0;
        f_out[`FLAG_C_NUM] = carry_out;
    end

endmodule

`default_nettype wire

// File: src/z80_cb_decode.sv
// ========================================================================
// Field decoder and legality check for the head CB instruction.
// ========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "z80_regs.svh"

module z80_cb_decode (
    input  z80_cb_pkg::cb_insn_u  head_insn,
    output z80_cb_pkg::bit_kind_e kind,
    output z80_cb_pkg::shift_op_e op,
    output logic [2:0]            bit_idx,
    output logic [2:0]            r,
    output logic                  legal
);

    import z80_cb_pkg::*;

    logic is_shift;
    logic is_sll;

    assign is_shift = (head_insn.shift_view.group == 2'b00);

    always_comb begin
        kind    = SHIFT_GRP;
        op      = RLC;
        bit_idx = 3'd0;
        if (is_shift) begin
            op = head_insn.shift_view.op; // RLC .. SRL.
            r  = head_insn.shift_view.r;
        end else begin
            kind    = head_insn.bit_view.kind;
            bit_idx = head_insn.bit_view.bit_idx;
            r       = head_insn.bit_view.r;
        end
    end

    // SLL is undocumented and rejected in strict mode.
    assign is_sll = (kind == SHIFT_GRP) && (op == SLL);

    assign legal = (head_insn.shift_view.prefix == CB_PREFIX) &&
                   (r != `REG_HL_IND) &&
                   !is_sll;

    // Both views overlay the same opcode bits.
    always_comb begin
        if (!$isunknown(head_insn)) begin
            assert ((kind == SHIFT_GRP) == (head_insn.shift_view.group == 2'b00))
                else $error("kind does not follow the opcode group");
        end
    end

endmodule

`default_nettype wire

// File: src/z80_cb_pkg.sv
// ========================================================================
// CB instruction word with its shift and bit views, operation codes and
// the parity helper.
// ========================================================================

package z80_cb_pkg;

    localparam logic [7:0] CB_PREFIX = 8'hCB;

    typedef enum logic [2:0] {
        RLC = 3'd0,
        RRC = 3'd1,
        RL  = 3'd2,
        RR  = 3'd3,
        SLA = 3'd4,
        SRA = 3'd5,
        SLL = 3'd6,
        SRL = 3'd7
    } shift_op_e;

    // Same encoding as the top two opcode bits.
    typedef enum logic [1:0] {
        SHIFT_GRP = 2'd0,
        BIT_TST   = 2'd1,
        BIT_RES   = 2'd2,
        BIT_SET   = 2'd3
    } bit_kind_e;

    // Opcode byte in 15:8, prefix byte in 7:0.
    typedef union packed {
        struct packed {
            logic [1:0] group;
            shift_op_e  op;
            logic [2:0] r;
            logic [7:0] prefix;
        } shift_view;
        struct packed {
            bit_kind_e  kind;
            logic [2:0] bit_idx;
            logic [2:0] r;
            logic [7:0] prefix;
        } bit_view;
    } cb_insn_u;

    // High for an even number of set bits.
    function automatic logic parity8(input logic [7:0] value);
        return ~^value;
    endfunction

endpackage

// File: include/z80_regs.svh
// ========================================================================
// Z80 register codes as used in the r field of CB opcodes, and the bit
// positions of the flags in F.
// ========================================================================

`ifndef Z80_REGS_SVH
`define Z80_REGS_SVH

`define REG_B      3'd0
`define REG_C      3'd1
`define REG_D      3'd2
`define REG_E      3'd3
`define REG_H      3'd4
`define REG_L      3'd5
`define REG_HL_IND 3'd6 // (HL) memory operand, not supported.
`define REG_A      3'd7

`define FLAG_S_NUM 7
`define FLAG_Z_NUM 6
`define FLAG_5_NUM 5
`define FLAG_H_NUM 4
`define FLAG_3_NUM 3
`define FLAG_V_NUM 2
`define FLAG_N_NUM 1
`define FLAG_C_NUM 0

`endif
